/* logic/decode_params.svh */
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// --------------------------------------------------
// Instruction set widths
// --------------------------------------------------
`define WORD_W 16 // Instruction and PC width
`define REG_W 4 // Register index width

// --------------------------------------------------
// Fixed register numbers
// --------------------------------------------------
`define SP_REG 4'd13
`define PC_REG 4'd15

// Sequential fetch advances by one halfword slot
`define PC_STEP 16'd1

`endif

/* logic/decode_pkg.sv */
`include "decode_params.svh"

package decode_pkg;

	// --------------------------------------------------
	// Instruction word views
	// --------------------------------------------------
	typedef struct packed {
		logic [3:0] op;
		logic [2:0] sub;
		logic [2:0] rm;
		logic [2:0] rn;
		logic [2:0] rd;
	} reg3_fmt_t;

	typedef struct packed {
		logic [3:0] op;
		logic [3:0] rd_cond; // Rd for MOVS, condition for B<cc>
		logic [7:0] imm8;
	} imm8_fmt_t;

	typedef struct packed {
		logic [3:0] op;
		logic rsvd;
		logic [10:0] offset;
	} imm11_fmt_t;

	typedef union packed {
		reg3_fmt_t reg3_fmt;
		imm8_fmt_t imm8_fmt;
		imm11_fmt_t imm11_fmt;
	} instr_u;

	// --------------------------------------------------
	// Operation encodings
	// --------------------------------------------------
	typedef enum logic [2:0] {
		ALU_NONE = 3'b000,
		ALU_ADD = 3'b001,
		ALU_SUB = 3'b010,
		ALU_AND = 3'b011,
		ALU_EOR = 3'b100,
		ALU_ORR = 3'b101,
		ALU_NOT = 3'b110,
		ALU_CMP = 3'b111
	} alu_op_e;

	typedef enum logic [1:0] {
		SHIFT_LSL = 2'b00,
		SHIFT_LSR = 2'b01,
		SHIFT_ASR = 2'b10,
		SHIFT_ROR = 2'b11
	} shift_op_e;

	// Write-back mux select
	typedef enum logic [3:0] {
		SEL_ADD = 4'b0000,
		SEL_SUB = 4'b0001,
		SEL_LOGIC = 4'b0010,
		SEL_EOR = 4'b0100,
		SEL_NOT = 4'b0101,
		SEL_CMP = 4'b0110,
		SEL_SHIFT = 4'b0111,
		SEL_CONST = 4'b1000,
		SEL_MOVE = 4'b1010,
		SEL_NONE = 4'b1111
	} result_sel_e;

	typedef struct packed {
		logic [`REG_W-1:0] rd_addr1;
		logic [`REG_W-1:0] rd_addr2;
		logic wr_en;
		logic [`REG_W-1:0] wr_addr;
		alu_op_e alu_op;
		shift_op_e shift_op;
		logic bx;
		logic branch_add;
		logic move_const;
		logic [`WORD_W-1:0] const1;
		logic [`WORD_W-1:0] const2;
		logic use_const; // Constant replaces second operand
		logic move;
		result_sel_e result_sel;
	} ctrl_t;

	localparam ctrl_t CTRL_NOP = '{
		rd_addr1: '0,
		rd_addr2: '0,
		wr_en: 1'b0,
		wr_addr: '0,
		alu_op: ALU_NONE,
		shift_op: SHIFT_LSL,
		bx: 1'b0,
		branch_add: 1'b0,
		move_const: 1'b0,
		const1: '0,
		const2: '0,
		use_const: 1'b0,
		move: 1'b0,
		result_sel: SEL_NONE
	};

endpackage

/* logic/alu_format_decode.sv */
`timescale 1ns/1ns
`include "decode_params.svh"

module alu_format_decode (
	input decode_pkg::instr_u instruction,
	output decode_pkg::ctrl_t alu_ctrl,
	output logic alu_hit
);

	logic [2:0] grp_sel; // Bits 10:8
	logic [3:0] dp_op; // Bits 9:6

	assign grp_sel = {instruction.reg3_fmt.sub[1:0], instruction.reg3_fmt.rm[2]};
	assign dp_op = {instruction.reg3_fmt.sub[0], instruction.reg3_fmt.rm};

	always_comb begin
		alu_ctrl = decode_pkg::CTRL_NOP;
		alu_hit = 1'b0;
		case (instruction.reg3_fmt.op)
			// --------------------------------------------------
			// ADDS / SUBS, register or imm3
			// --------------------------------------------------
			4'b0001: begin
				alu_hit = 1'b1;
				alu_ctrl.rd_addr1 = {1'b0, instruction.reg3_fmt.rn};
				alu_ctrl.wr_en = 1'b1;
				alu_ctrl.wr_addr = {1'b0, instruction.reg3_fmt.rd};
				if (instruction.reg3_fmt.sub[0]) begin
					alu_ctrl.alu_op = decode_pkg::ALU_SUB;
					alu_ctrl.result_sel = decode_pkg::SEL_SUB;
				end else begin
					alu_ctrl.alu_op = decode_pkg::ALU_ADD;
					alu_ctrl.result_sel = decode_pkg::SEL_ADD;
				end
				if (instruction.reg3_fmt.sub[1]) begin // imm3 in the Rm slot
					alu_ctrl.const2 = {{(`WORD_W-3){1'b0}}, instruction.reg3_fmt.rm};
					alu_ctrl.use_const = 1'b1;
				end else begin
					alu_ctrl.rd_addr2 = {1'b0, instruction.reg3_fmt.rm};
				end
			end
			4'b0010: begin // MOVS imm8
				alu_hit = 1'b1;
				alu_ctrl.wr_en = 1'b1;
				alu_ctrl.wr_addr = {1'b0, instruction.imm8_fmt.rd_cond[2:0]};
				alu_ctrl.move_const = 1'b1;
				alu_ctrl.const1 = {{(`WORD_W-8){1'b0}}, instruction.imm8_fmt.imm8};
				alu_ctrl.result_sel = decode_pkg::SEL_CONST;
			end
			// --------------------------------------------------
			// MOV and data processing
			// --------------------------------------------------
			4'b0100: begin
				if (grp_sel == 3'b110) begin
					alu_hit = 1'b1;
					alu_ctrl.rd_addr1 = {instruction.reg3_fmt.rm[0], instruction.reg3_fmt.rn};
					alu_ctrl.wr_en = 1'b1;
					alu_ctrl.wr_addr = {instruction.reg3_fmt.rm[1], instruction.reg3_fmt.rd};
					alu_ctrl.move = 1'b1;
					alu_ctrl.result_sel = decode_pkg::SEL_MOVE;
				end else if (grp_sel != 3'b111 && grp_sel != 3'b101) begin
					alu_hit = 1'b1;
					alu_ctrl.rd_addr1 = {1'b0, instruction.reg3_fmt.rd};
					alu_ctrl.rd_addr2 = {1'b0, instruction.reg3_fmt.rn};
					alu_ctrl.wr_en = 1'b1;
					alu_ctrl.wr_addr = {1'b0, instruction.reg3_fmt.rd};
					case (dp_op)
						4'b0000: begin
							alu_ctrl.alu_op = decode_pkg::ALU_AND;
							alu_ctrl.result_sel = decode_pkg::SEL_LOGIC;
						end
						4'b0001: begin
							alu_ctrl.alu_op = decode_pkg::ALU_EOR;
							alu_ctrl.result_sel = decode_pkg::SEL_EOR;
						end
						4'b0010: begin
							alu_ctrl.result_sel = decode_pkg::SEL_SHIFT; // LSLS
						end
						4'b0011: begin
							alu_ctrl.alu_op = decode_pkg::ALU_EOR;
							alu_ctrl.shift_op = decode_pkg::SHIFT_LSR;
							alu_ctrl.result_sel = decode_pkg::SEL_SHIFT;
						end
						4'b0100: begin
							alu_ctrl.alu_op = decode_pkg::ALU_EOR;
							alu_ctrl.shift_op = decode_pkg::SHIFT_ASR;
							alu_ctrl.result_sel = decode_pkg::SEL_SHIFT;
						end
						4'b0111: begin
							alu_ctrl.alu_op = decode_pkg::ALU_EOR;
							alu_ctrl.shift_op = decode_pkg::SHIFT_ROR;
							alu_ctrl.result_sel = decode_pkg::SEL_SHIFT;
						end
						4'b1010: begin // Flags only
							alu_ctrl.wr_en = 1'b0;
							alu_ctrl.alu_op = decode_pkg::ALU_CMP;
							alu_ctrl.result_sel = decode_pkg::SEL_CMP;
						end
						4'b1100: begin
							alu_ctrl.alu_op = decode_pkg::ALU_ORR;
							alu_ctrl.result_sel = decode_pkg::SEL_LOGIC;
						end
						4'b1111: begin
							alu_ctrl.alu_op = decode_pkg::ALU_NOT;
							alu_ctrl.result_sel = decode_pkg::SEL_NOT;
						end
						default: begin // BX lands here and belongs to branch_decode
							alu_hit = 1'b0;
							alu_ctrl = decode_pkg::CTRL_NOP;
						end
					endcase
				end
			end
			4'b1011: begin
				if (!instruction.imm8_fmt.rd_cond[3]) begin // SP adjust
					alu_hit = 1'b1;
					alu_ctrl.rd_addr1 = `SP_REG;
					alu_ctrl.wr_en = 1'b1;
					alu_ctrl.wr_addr = `SP_REG;
					alu_ctrl.const1 = {{(`WORD_W-7){1'b0}}, instruction.imm8_fmt.imm8[6:0]};
					alu_ctrl.use_const = 1'b1;
					if (instruction.imm8_fmt.imm8[7]) begin
						alu_ctrl.alu_op = decode_pkg::ALU_ADD;
						alu_ctrl.result_sel = decode_pkg::SEL_ADD;
					end else begin
						alu_ctrl.alu_op = decode_pkg::ALU_SUB;
						alu_ctrl.result_sel = decode_pkg::SEL_SUB;
					end
				end
			end
			default: ;
		endcase
	end

endmodule

/* logic/branch_decode.sv */
`timescale 1ns/1ns
`include "decode_params.svh"

module branch_decode (
	input decode_pkg::instr_u instruction,
	input logic [`WORD_W-1:0] pc,
	output decode_pkg::ctrl_t br_ctrl,
	output logic br_hit,
	output logic [`WORD_W-1:0] br_next_pc
);

	logic [`WORD_W-1:0] imm8_ext;
	logic [`WORD_W-1:0] imm11_ext;

	assign imm8_ext = {{(`WORD_W-8){1'b0}}, instruction.imm8_fmt.imm8};
	assign imm11_ext = {{(`WORD_W-11){1'b0}}, instruction.imm11_fmt.offset};

	always_comb begin
		br_ctrl = decode_pkg::CTRL_NOP;
		br_hit = 1'b0;
		br_next_pc = pc + `PC_STEP;
		case (instruction.imm8_fmt.op)
			4'b1101: begin // B<cc>
				br_hit = 1'b1;
				br_ctrl.rd_addr1 = `PC_REG;
				br_ctrl.wr_en = 1'b1;
				br_ctrl.wr_addr = `PC_REG;
				br_ctrl.alu_op = decode_pkg::ALU_ADD;
				br_ctrl.branch_add = 1'b1;
				if (instruction.imm8_fmt.rd_cond != 4'd0) begin
					br_ctrl.const1 = imm8_ext;
					br_ctrl.result_sel = decode_pkg::SEL_ADD;
					br_next_pc = pc + imm8_ext;
				end
			end
			4'b1110: begin // B
				br_hit = 1'b1;
				br_ctrl.rd_addr1 = `PC_REG;
				br_ctrl.wr_en = 1'b1;
				br_ctrl.wr_addr = `PC_REG;
				br_ctrl.alu_op = decode_pkg::ALU_ADD;
				br_ctrl.branch_add = 1'b1;
				br_next_pc = pc + imm11_ext;
			end
			4'b0100: begin
				// BX Rm, target register index passed in const1
				if ({instruction.reg3_fmt.sub[1:0], instruction.reg3_fmt.rm} == 5'b01110) begin
					br_hit = 1'b1;
					br_ctrl.wr_en = 1'b1;
					br_ctrl.wr_addr = `PC_REG;
					br_ctrl.bx = 1'b1;
					br_ctrl.const1 = {{(`WORD_W-4){1'b0}}, instruction.reg3_fmt.rm[0],
						instruction.reg3_fmt.rn};
				end
			end
			default: ;
		endcase
	end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ns
`include "decode_params.svh"

module decode_stage (
	input logic clk,
	input logic reset,
	input logic fetched,
	input logic [`WORD_W-1:0] pc,
	input decode_pkg::ctrl_t alu_ctrl,
	input decode_pkg::ctrl_t br_ctrl,
	input logic alu_hit,
	input logic br_hit,
	input logic [`WORD_W-1:0] br_next_pc,
	output decode_pkg::ctrl_t ctrl,
	output logic [`WORD_W-1:0] next_pc,
	output logic valid
);

	decode_pkg::ctrl_t ctrl_sel;
	logic [`WORD_W-1:0] pc_sel;

	// --------------------------------------------------
	// Claim select and fetch gate
	// --------------------------------------------------
	always_comb begin
		ctrl_sel = decode_pkg::CTRL_NOP;
		if (fetched && br_hit) begin
			ctrl_sel = br_ctrl;
		end else if (fetched && alu_hit) begin
			ctrl_sel = alu_ctrl;
		end
	end

	// Sequential PC unless a fetched branch redirects
	assign pc_sel = (fetched && br_hit) ? br_next_pc : pc + `PC_STEP;

	// --------------------------------------------------
	// Output register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl <= decode_pkg::CTRL_NOP;
			next_pc <= '0;
			valid <= 1'b0;
		end else begin
			ctrl <= ctrl_sel;
			next_pc <= pc_sel;
			valid <= fetched;
		end
	end

endmodule

/* logic/thumb_decoder.sv */
`timescale 1ns/1ns
`include "decode_params.svh"

module thumb_decoder (
	input logic clk,
	input logic reset,
	input logic fetched, // Instruction valid
	input decode_pkg::instr_u instruction,
	input logic [`WORD_W-1:0] pc,
	output decode_pkg::ctrl_t ctrl,
	output logic [`WORD_W-1:0] next_pc,
	output logic valid
);

	decode_pkg::ctrl_t alu_ctrl;
	decode_pkg::ctrl_t br_ctrl;
	logic alu_hit;
	logic br_hit;
	logic [`WORD_W-1:0] br_next_pc;

	alu_format_decode u_alu_format_decode (
		.instruction(instruction),
		.alu_ctrl(alu_ctrl),
		.alu_hit(alu_hit)
	);

	branch_decode u_branch_decode (
		.instruction(instruction),
		.pc(pc),
		.br_ctrl(br_ctrl),
		.br_hit(br_hit),
		.br_next_pc(br_next_pc)
	);

	decode_stage u_decode_stage (
		.clk(clk),
		.reset(reset),
		.fetched(fetched),
		.pc(pc),
		.alu_ctrl(alu_ctrl),
		.br_ctrl(br_ctrl),
		.alu_hit(alu_hit),
		.br_hit(br_hit),
		.br_next_pc(br_next_pc),
		.ctrl(ctrl),
		.next_pc(next_pc),
		.valid(valid)
	);

endmodule

/* tests/thumb_decoder_props.sv */
`timescale 1ns/1ns

module thumb_decoder_props (
	input logic clk,
	input logic reset,
	input logic fetched,
	input decode_pkg::ctrl_t ctrl,
	input logic valid
);

	a_reset_state: assert property (@(posedge clk)
		reset |=> (!valid && ctrl == decode_pkg::CTRL_NOP))
		else $error("Outputs not cleared one cycle after reset");

	a_valid_follows: assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> (valid == $past(fetched)))
		else $error("valid does not follow fetched by one cycle");

	a_idle_nop: assert property (@(posedge clk) disable iff (reset)
		!fetched |=> (ctrl == decode_pkg::CTRL_NOP))
		else $error("Control word not idle after a cycle without fetch");

	// Only branches write with no unit result selected
	a_wr_has_sel: assert property (@(posedge clk)
		(ctrl.wr_en && ctrl.result_sel == decode_pkg::SEL_NONE) |-> (ctrl.bx || ctrl.branch_add))
		else $error("Register write with no result select outside a branch");

endmodule

bind thumb_decoder thumb_decoder_props u_thumb_decoder_props (
	.clk(clk),
	.reset(reset),
	.fetched(fetched),
	.ctrl(ctrl),
	.valid(valid)
);

/* tests/thumb_decoder_tb.sv */
`timescale 1ns/1ns
`include "decode_params.svh"

module thumb_decoder_tb;

	localparam int N_TXN = 2000;
	localparam int TIMEOUT_NS = (N_TXN + 8) * 4 + 100;

	typedef struct packed {
		decode_pkg::ctrl_t ctrl;
		logic [`WORD_W-1:0] next_pc;
		logic valid;
	} result_t;

	logic clk;
	logic reset;
	logic fetched;
	decode_pkg::instr_u instruction;
	logic [`WORD_W-1:0] pc;
	decode_pkg::ctrl_t ctrl;
	logic [`WORD_W-1:0] next_pc;
	logic valid;

	result_t exp_q[$];
	logic [15:0] instr_q[$]; // Instruction words for error lines

	thumb_decoder u_thumb_decoder (
		.clk(clk),
		.reset(reset),
		.fetched(fetched),
		.instruction(instruction),
		.pc(pc),
		.ctrl(ctrl),
		.next_pc(next_pc),
		.valid(valid)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	function automatic result_t expect_result(input logic f, input logic [15:0] w,
		input logic [15:0] p);
		result_t r;
		decode_pkg::ctrl_t c;
		c = decode_pkg::CTRL_NOP;
		r.next_pc = p + 16'd1;
		case (w[15:12])
			4'h1: begin // ADDS / SUBS
				c.rd_addr1 = {1'b0, w[5:3]};
				c.wr_en = 1'b1;
				c.wr_addr = {1'b0, w[2:0]};
				if (w[9]) begin
					c.alu_op = decode_pkg::ALU_SUB;
					c.result_sel = decode_pkg::SEL_SUB;
				end else begin
					c.alu_op = decode_pkg::ALU_ADD;
					c.result_sel = decode_pkg::SEL_ADD;
				end
				if (w[10]) begin
					c.const2 = {13'd0, w[8:6]};
					c.use_const = 1'b1;
				end else begin
					c.rd_addr2 = {1'b0, w[8:6]};
				end
			end
			4'h2: begin // MOVS imm8
				c.wr_en = 1'b1;
				c.wr_addr = {1'b0, w[10:8]};
				c.move_const = 1'b1;
				c.const1 = {8'd0, w[7:0]};
				c.result_sel = decode_pkg::SEL_CONST;
			end
			4'h4: begin
				if (w[10:8] == 3'b110) begin // MOV with D in bit 7
					c.rd_addr1 = w[6:3];
					c.wr_en = 1'b1;
					c.wr_addr = {w[7], w[2:0]};
					c.move = 1'b1;
					c.result_sel = decode_pkg::SEL_MOVE;
				end else if (w[10:6] == 5'b01110) begin // BX
					c.wr_en = 1'b1;
					c.wr_addr = `PC_REG;
					c.bx = 1'b1;
					c.const1 = {12'd0, w[6:3]};
				end else if (w[10:8] != 3'b111 && w[10:8] != 3'b101) begin
					c.rd_addr1 = {1'b0, w[2:0]};
					c.rd_addr2 = {1'b0, w[5:3]};
					c.wr_en = 1'b1;
					c.wr_addr = {1'b0, w[2:0]};
					// Shifts other than LSLS carry the EOR op code
					case (w[9:6])
						4'h0: begin
							c.alu_op = decode_pkg::ALU_AND;
							c.result_sel = decode_pkg::SEL_LOGIC;
						end
						4'h1: begin
							c.alu_op = decode_pkg::ALU_EOR;
							c.result_sel = decode_pkg::SEL_EOR;
						end
						4'h2: c.result_sel = decode_pkg::SEL_SHIFT;
						4'h3: begin
							c.alu_op = decode_pkg::ALU_EOR;
							c.shift_op = decode_pkg::SHIFT_LSR;
							c.result_sel = decode_pkg::SEL_SHIFT;
						end
						4'h4: begin
							c.alu_op = decode_pkg::ALU_EOR;
							c.shift_op = decode_pkg::SHIFT_ASR;
							c.result_sel = decode_pkg::SEL_SHIFT;
						end
						4'h7: begin
							c.alu_op = decode_pkg::ALU_EOR;
							c.shift_op = decode_pkg::SHIFT_ROR;
							c.result_sel = decode_pkg::SEL_SHIFT;
						end
						4'hA: begin // CMP sets flags only
							c.wr_en = 1'b0;
							c.alu_op = decode_pkg::ALU_CMP;
							c.result_sel = decode_pkg::SEL_CMP;
						end
						4'hC: begin
							c.alu_op = decode_pkg::ALU_ORR;
							c.result_sel = decode_pkg::SEL_LOGIC;
						end
						4'hF: begin
							c.alu_op = decode_pkg::ALU_NOT;
							c.result_sel = decode_pkg::SEL_NOT;
						end
						default: c = decode_pkg::CTRL_NOP;
					endcase
				end
			end
			4'hB: begin
				if (!w[11]) begin // ADD SP / SUB SP
					c.rd_addr1 = `SP_REG;
					c.wr_en = 1'b1;
					c.wr_addr = `SP_REG;
					c.const1 = {9'd0, w[6:0]};
					c.use_const = 1'b1;
					if (w[7]) begin
						c.alu_op = decode_pkg::ALU_ADD;
						c.result_sel = decode_pkg::SEL_ADD;
					end else begin
						c.alu_op = decode_pkg::ALU_SUB;
						c.result_sel = decode_pkg::SEL_SUB;
					end
				end
			end
			4'hD, 4'hE: begin
				c.rd_addr1 = `PC_REG;
				c.wr_en = 1'b1;
				c.wr_addr = `PC_REG;
				c.alu_op = decode_pkg::ALU_ADD;
				c.branch_add = 1'b1;
				if (w[15:12] == 4'hE) begin
					r.next_pc = p + {5'd0, w[10:0]};
				end else if (w[11:8] != 4'd0) begin
					c.const1 = {8'd0, w[7:0]};
					c.result_sel = decode_pkg::SEL_ADD;
					r.next_pc = p + {8'd0, w[7:0]};
				end
			end
			default: ;
		endcase
		if (!f) begin
			c = decode_pkg::CTRL_NOP;
			r.next_pc = p + 16'd1;
		end
		r.ctrl = c;
		r.valid = f;
		return r;
	endfunction

	function automatic logic [15:0] random_instr();
		logic [31:0] r;
		logic [3:0] op;
		r = $urandom;
		case (r[18:16]) // Six in eight land on a kept group
			3'd0: op = 4'h1;
			3'd1: op = 4'h2;
			3'd2: op = 4'h4;
			3'd3: op = 4'hB;
			3'd4: op = 4'hD;
			3'd5: op = 4'hE;
			default: op = r[15:12];
		endcase
		return {op, r[11:0]};
	endfunction

	task automatic check_result();
		result_t exp;
		result_t got;
		logic [15:0] w;
		exp = exp_q.pop_front();
		w = instr_q.pop_front();
		got.ctrl = ctrl;
		got.next_pc = next_pc;
		got.valid = valid;
		assert (got == exp) else begin
			$display("CHECK FAILED at %0t: instr %h gave ctrl=%h next_pc=%h valid=%b,",
				$time, w, got.ctrl, got.next_pc, got.valid);
			$display("  expected ctrl=%h next_pc=%h valid=%b",
				exp.ctrl, exp.next_pc, exp.valid);
			$display("Regression failed");
			$fatal(1, "Output mismatch");
		end
	endtask

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	initial begin
		result_t rst_exp;
		logic [31:0] rnd;
		void'($urandom(54765));
		reset = 1'b1;
		fetched = 1'b0;
		instruction = '0;
		pc = '0;
		rst_exp.ctrl = decode_pkg::CTRL_NOP;
		rst_exp.next_pc = '0;
		rst_exp.valid = 1'b0;
		exp_q.push_back(rst_exp);
		instr_q.push_back(16'd0);
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < N_TXN; i++) begin
			check_result();
			rnd = $urandom;
			fetched = (rnd[2:0] != 3'd0); // Idle about one cycle in eight
			instruction = random_instr();
			pc = rnd[31:16];
			exp_q.push_back(expect_result(fetched, instruction, pc));
			instr_q.push_back(instruction);
			@(negedge clk);
		end
		check_result();
		$display("Regression passed");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before all transactions were checked");
		$display("Regression failed");
		$fatal(1, "Timeout");
	end

endmodule

/* filelist.f */
+incdir+logic
logic/decode_pkg.sv
logic/alu_format_decode.sv
logic/branch_decode.sv
logic/decode_stage.sv
logic/thumb_decoder.sv
tests/thumb_decoder_props.sv
tests/thumb_decoder_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f filelist.f --top-module thumb_decoder_tb -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit $status
fi
exit 0
